/* source/axi_write_pkg.sv */
package axi_write_pkg;

  // bus geometry
  localparam int AXI_AWIDTH = 32;
  localparam int AXI_DWIDTH = 32;
  localparam int NUM_DBYTES = AXI_DWIDTH / 8;
  localparam logic [2:0] AXI_SIZE = 3'd2;
  localparam int AXI_LEN_W = 8;

  // burst splitting
  localparam int MAX_BURST_LEN = 16;
  localparam int LEN_W = 12;

  // credit queues, depth equals the core's initial credits
  localparam int CMD_CREDITS = 4;
  localparam int CMD_PTR_W = $clog2(CMD_CREDITS);
  localparam int DATA_CREDITS = 16;
  localparam int DATA_PTR_W = $clog2(DATA_CREDITS);

  // last-burst marks waiting for their B response
  localparam int MARK_DEPTH = 2;
  localparam int MARK_PTR_W = $clog2(MARK_DEPTH);

  // AXI codes
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] BURST_INCR = 2'b01;

  // AW and W channel state codes
  localparam logic [1:0] ST_IDLE = 2'b00;
  localparam logic [1:0] ST_RUN = 2'b01;
  localparam logic [1:0] ST_DONE = 2'b10;

endpackage

/* source/write_cmd_intake.sv */
`timescale 1ns/10ps

module write_cmd_intake (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 cmd_valid,
  input  logic [axi_write_pkg::AXI_AWIDTH-1:0] cmd_addr,
  input  logic [axi_write_pkg::LEN_W-1:0]      cmd_len,
  input  logic                                 cmd_pop,
  output logic                                 cmd_avail,
  output logic [axi_write_pkg::AXI_AWIDTH-1:0] head_addr,
  output logic [axi_write_pkg::LEN_W-1:0]      head_len,
  output logic                                 cmd_credit
);

  import axi_write_pkg::*;

  logic [AXI_AWIDTH-1:0] addr_mem [CMD_CREDITS];
  logic [LEN_W-1:0]      len_mem  [CMD_CREDITS];

  // extra top bit tells full from empty
  logic [CMD_PTR_W:0]   wr_ptr;
  logic [CMD_PTR_W:0]   rd_ptr;
  logic [CMD_PTR_W-1:0] wr_idx;
  logic [CMD_PTR_W-1:0] rd_idx;

  assign wr_idx = wr_ptr[CMD_PTR_W-1:0];
  assign rd_idx = rd_ptr[CMD_PTR_W-1:0];

  // no ready, the core only sends while it holds a credit
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      addr_mem[wr_idx] <= cmd_addr;
      len_mem[wr_idx]  <= cmd_len;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      cmd_credit <= 1'b0;
    end else begin
      if (cmd_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (cmd_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // one credit back per entry consumed
      cmd_credit <= cmd_pop;
    end
  end

  assign cmd_avail = (wr_ptr != rd_ptr);
  assign head_addr = addr_mem[rd_idx];
  assign head_len  = len_mem[rd_idx];

endmodule

/* source/write_data_buffer.sv */
`timescale 1ns/10ps

module write_data_buffer (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 data_valid,
  input  logic [axi_write_pkg::AXI_DWIDTH-1:0] data_word,
  input  logic                                 data_pop,
  output logic                                 data_avail,
  output logic [axi_write_pkg::AXI_DWIDTH-1:0] head_data,
  output logic                                 data_credit
);

  import axi_write_pkg::*;

  logic [AXI_DWIDTH-1:0] data_mem [DATA_CREDITS];

  logic [DATA_PTR_W:0]   wr_ptr;
  logic [DATA_PTR_W:0]   rd_ptr;
  logic [DATA_PTR_W-1:0] wr_idx;
  logic [DATA_PTR_W-1:0] rd_idx;

  assign wr_idx = wr_ptr[DATA_PTR_W-1:0];
  assign rd_idx = rd_ptr[DATA_PTR_W-1:0];

  // data may arrive ahead of its command, it just waits here
  always_ff @(posedge clk) begin
    if (data_valid) begin
      data_mem[wr_idx] <= data_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      data_credit <= 1'b0;
    end else begin
      if (data_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // pop is the W handshake
      if (data_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      data_credit <= data_pop;
    end
  end

  // empty when both pointers agree, wrap bit included
  assign data_avail = (wr_ptr != rd_ptr);
  assign head_data  = data_mem[rd_idx];

endmodule

/* source/axi_mm_write.sv */
`timescale 1ns/10ps

module axi_mm_write (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 cmd_avail,
  input  logic [axi_write_pkg::AXI_AWIDTH-1:0] head_addr,
  input  logic [axi_write_pkg::LEN_W-1:0]      head_len,
  input  logic                                 data_avail,
  input  logic [axi_write_pkg::AXI_DWIDTH-1:0] head_data,
  input  logic                                 awready,
  input  logic                                 wready,
  input  logic                                 bvalid,
  input  logic                                 bready,
  output logic                                 cmd_pop,
  output logic                                 data_pop,
  output logic [axi_write_pkg::AXI_AWIDTH-1:0] awaddr,
  output logic [axi_write_pkg::AXI_LEN_W-1:0]  awlen,
  output logic [2:0]                           awsize,
  output logic [1:0]                           awburst,
  output logic                                 awvalid,
  output logic [axi_write_pkg::AXI_DWIDTH-1:0] wdata,
  output logic [axi_write_pkg::NUM_DBYTES-1:0] wstrb,
  output logic                                 wlast,
  output logic                                 wvalid,
  output logic                                 burst_issued,
  output logic                                 burst_is_last
);

  import axi_write_pkg::*;

  logic [1:0]            aw_state;
  logic [1:0]            aw_state_next;
  logic [1:0]            w_state;
  logic [1:0]            w_state_next;

  // working address and remaining beats minus one
  logic [AXI_AWIDTH-1:0] addr_q;
  logic [LEN_W-1:0]      len_q;
  logic [AXI_AWIDTH-1:0] next_addr;
  logic [LEN_W-1:0]      next_len;
  logic                  next_full;

  // current burst, held stable while AW waits
  logic [AXI_AWIDTH-1:0] awaddr_q;
  logic [AXI_LEN_W-1:0]  awlen_q;
  logic                  last_q;

  logic [AXI_LEN_W-1:0]  beat_cnt;
  logic                  resume;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;
  logic                  idle;
  logic                  start;

  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;
  assign b_fire  = bvalid & bready;

  assign idle    = (aw_state == ST_IDLE) & (w_state == ST_IDLE);
  assign cmd_pop = idle & ~resume & cmd_avail;
  assign start   = cmd_pop | (idle & resume);

  // a follow-on burst picks up from the advanced working registers
  assign next_addr = resume ? addr_q : head_addr;
  assign next_len  = resume ? len_q : head_len;
  assign next_full = next_len > LEN_W'(MAX_BURST_LEN - 1);

  always_comb begin
    aw_state_next = aw_state;
    case (aw_state)
      ST_IDLE: begin
        if (start) begin
          aw_state_next = ST_RUN;
        end
      end
      ST_RUN: begin
        if (aw_fire) begin
          aw_state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        if (b_fire) begin
          aw_state_next = ST_IDLE;
        end
      end
      default: aw_state_next = ST_IDLE;
    endcase
  end

  always_comb begin
    w_state_next = w_state;
    case (w_state)
      ST_IDLE: begin
        if (start) begin
          w_state_next = ST_RUN;
        end
      end
      ST_RUN: begin
        if (w_fire && wlast) begin
          w_state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        if (b_fire) begin
          w_state_next = ST_IDLE;
        end
      end
      default: w_state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      aw_state <= ST_IDLE;
      w_state  <= ST_IDLE;
      resume   <= 1'b0;
      beat_cnt <= '0;
    end else begin
      aw_state <= aw_state_next;
      w_state  <= w_state_next;
      if (start) begin
        resume   <= 1'b0;
        beat_cnt <= '0;
      end else if (w_fire) begin
        beat_cnt <= beat_cnt + 1'b1;
        // more beats left after a full burst
        if (wlast) begin
          resume <= ~last_q;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      awaddr_q <= next_addr;
      awlen_q  <= next_full ? AXI_LEN_W'(MAX_BURST_LEN - 1) : next_len[AXI_LEN_W-1:0];
      last_q   <= ~next_full;
      addr_q   <= next_addr;
      len_q    <= next_len;
    end else if (w_fire && wlast) begin
      addr_q <= addr_q + AXI_AWIDTH'(MAX_BURST_LEN * NUM_DBYTES);
      len_q  <= len_q - LEN_W'(MAX_BURST_LEN);
    end
  end

  assign awaddr  = awaddr_q;
  assign awlen   = awlen_q;
  assign awsize  = AXI_SIZE;
  assign awburst = BURST_INCR;
  assign awvalid = (aw_state == ST_RUN);

  assign wdata    = head_data;
  assign wvalid   = (w_state == ST_RUN) & data_avail;
  assign wlast    = (w_state == ST_RUN) & (beat_cnt == awlen_q);
  assign wstrb    = (w_state == ST_RUN) ? {NUM_DBYTES{1'b1}} : {NUM_DBYTES{1'b0}};
  assign data_pop = w_fire;

  assign burst_issued  = aw_fire;
  assign burst_is_last = last_q;

endmodule

/* source/write_resp_collector.sv */
`timescale 1ns/10ps

module write_resp_collector (
  input  logic       clk,
  input  logic       reset,
  input  logic       burst_issued,
  input  logic       burst_is_last,
  input  logic       bvalid,
  input  logic [1:0] bresp,
  output logic       bready,
  output logic       done,
  output logic       done_err
);

  import axi_write_pkg::*;

  logic                  mark_mem [MARK_DEPTH];
  logic [MARK_PTR_W:0]   wr_ptr;
  logic [MARK_PTR_W:0]   rd_ptr;
  logic                  err_acc;
  logic                  b_fire;
  logic                  b_bad;

  // one mark per AW handshake
  always_ff @(posedge clk) begin
    if (burst_issued) begin
      mark_mem[wr_ptr[MARK_PTR_W-1:0]] <= burst_is_last;
    end
  end

  assign bready = (wr_ptr != rd_ptr);
  assign b_fire = bvalid & bready;
  assign b_bad  = (bresp != RESP_OKAY);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      err_acc  <= 1'b0;
      done     <= 1'b0;
      done_err <= 1'b0;
    end else begin
      done     <= 1'b0;
      done_err <= 1'b0;
      if (burst_issued) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (b_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
        if (mark_mem[rd_ptr[MARK_PTR_W-1:0]]) begin
          // last burst closes the command
          done     <= 1'b1;
          done_err <= err_acc | b_bad;
          err_acc  <= 1'b0;
        end else begin
          err_acc <= err_acc | b_bad;
        end
      end
    end
  end

endmodule

/* source/axi_write_dma.sv */
`timescale 1ns/10ps

module axi_write_dma (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 cmd_valid,
  input  logic [axi_write_pkg::AXI_AWIDTH-1:0] cmd_addr,
  input  logic [axi_write_pkg::LEN_W-1:0]      cmd_len,
  output logic                                 cmd_credit,
  input  logic                                 data_valid,
  input  logic [axi_write_pkg::AXI_DWIDTH-1:0] data_word,
  output logic                                 data_credit,
  output logic [axi_write_pkg::AXI_AWIDTH-1:0] awaddr,
  output logic [axi_write_pkg::AXI_LEN_W-1:0]  awlen,
  output logic [2:0]                           awsize,
  output logic [1:0]                           awburst,
  output logic                                 awvalid,
  input  logic                                 awready,
  output logic [axi_write_pkg::AXI_DWIDTH-1:0] wdata,
  output logic [axi_write_pkg::NUM_DBYTES-1:0] wstrb,
  output logic                                 wlast,
  output logic                                 wvalid,
  input  logic                                 wready,
  input  logic [1:0]                           bresp,
  input  logic                                 bvalid,
  output logic                                 bready,
  output logic                                 done,
  output logic                                 done_err
);

  import axi_write_pkg::*;

  logic                  cmd_avail;
  logic                  cmd_pop;
  logic [AXI_AWIDTH-1:0] head_addr;
  logic [LEN_W-1:0]      head_len;
  logic                  data_avail;
  logic                  data_pop;
  logic [AXI_DWIDTH-1:0] head_data;
  logic                  burst_issued;
  logic                  burst_is_last;

  write_cmd_intake u_write_cmd_intake (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_addr   (cmd_addr),
    .cmd_len    (cmd_len),
    .cmd_pop    (cmd_pop),
    .cmd_avail  (cmd_avail),
    .head_addr  (head_addr),
    .head_len   (head_len),
    .cmd_credit (cmd_credit)
  );

  write_data_buffer u_write_data_buffer (
    .clk         (clk),
    .reset       (reset),
    .data_valid  (data_valid),
    .data_word   (data_word),
    .data_pop    (data_pop),
    .data_avail  (data_avail),
    .head_data   (head_data),
    .data_credit (data_credit)
  );

  axi_mm_write u_axi_mm_write (
    .clk           (clk),
    .reset         (reset),
    .cmd_avail     (cmd_avail),
    .head_addr     (head_addr),
    .head_len      (head_len),
    .data_avail    (data_avail),
    .head_data     (head_data),
    .awready       (awready),
    .wready        (wready),
    .bvalid        (bvalid),
    .bready        (bready),
    .cmd_pop       (cmd_pop),
    .data_pop      (data_pop),
    .awaddr        (awaddr),
    .awlen         (awlen),
    .awsize        (awsize),
    .awburst       (awburst),
    .awvalid       (awvalid),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wlast         (wlast),
    .wvalid        (wvalid),
    .burst_issued  (burst_issued),
    .burst_is_last (burst_is_last)
  );

  // bready comes from here and is shared with the engine
  write_resp_collector u_write_resp_collector (
    .clk           (clk),
    .reset         (reset),
    .burst_issued  (burst_issued),
    .burst_is_last (burst_is_last),
    .bvalid        (bvalid),
    .bresp         (bresp),
    .bready        (bready),
    .done          (done),
    .done_err      (done_err)
  );

endmodule

/* test/axi_write_dma_assertions.sv */
`timescale 1ns/10ps

module axi_write_dma_assertions (
  input logic                                 clk,
  input logic                                 reset,
  input logic                                 awvalid,
  input logic                                 awready,
  input logic [axi_write_pkg::AXI_AWIDTH-1:0] awaddr,
  input logic [axi_write_pkg::AXI_LEN_W-1:0]  awlen,
  input logic                                 wvalid,
  input logic                                 wready,
  input logic                                 wlast,
  input logic [axi_write_pkg::AXI_DWIDTH-1:0] wdata,
  input logic                                 bvalid,
  input logic                                 bready,
  input logic                                 cmd_credit,
  input logic                                 done
);

  int failures = 0;

  // AW and W stay put until accepted
  aw_hold: assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
    else begin
      failures++;
      $error("AW dropped or changed before its handshake");
    end

  w_hold: assert property (@(posedge clk) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else begin
      failures++;
      $error("W dropped or changed before its handshake");
    end

  // completion follows a B handshake by one cycle
  done_after_b: assert property (@(posedge clk) disable iff (reset)
    done |-> $past(bvalid && bready))
    else begin
      failures++;
      $error("done without a B handshake in the cycle before");
    end

  // one pop per idle cycle, so never two in a row
  cmd_credit_pulse: assert property (@(posedge clk) disable iff (reset)
    cmd_credit |=> !cmd_credit)
    else begin
      failures++;
      $error("cmd_credit high for two cycles");
    end

  done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      failures++;
      $error("done high for two cycles");
    end

endmodule

bind axi_write_dma axi_write_dma_assertions u_assertions (.*);

/* test/axi_write_dma_tb.sv */
`timescale 1ns/10ps

module axi_write_dma_tb;

  import axi_write_pkg::*;

  localparam int NUM_CMDS = 40;
  localparam int MAX_BEATS = 70;
  localparam int CYCLE_LIMIT = NUM_CMDS * MAX_BEATS * 8 + 2000;

  logic                  clk = 1'b0;
  logic                  reset = 1'b1;
  logic                  cmd_valid = 1'b0;
  logic [AXI_AWIDTH-1:0] cmd_addr = '0;
  logic [LEN_W-1:0]      cmd_len = '0;
  logic                  cmd_credit;
  logic                  data_valid = 1'b0;
  logic [AXI_DWIDTH-1:0] data_word = '0;
  logic                  data_credit;
  logic [AXI_AWIDTH-1:0] awaddr;
  logic [AXI_LEN_W-1:0]  awlen;
  logic [2:0]            awsize;
  logic [1:0]            awburst;
  logic                  awvalid;
  logic                  awready = 1'b0;
  logic [AXI_DWIDTH-1:0] wdata;
  logic [NUM_DBYTES-1:0] wstrb;
  logic                  wlast;
  logic                  wvalid;
  logic                  wready = 1'b0;
  logic [1:0]            bresp = RESP_OKAY;
  logic                  bvalid = 1'b0;
  logic                  bready;
  logic                  done;
  logic                  done_err;

  // reference model, one entry per expected burst
  bit [31:0] exp_mem [bit [31:0]];
  bit [31:0] mem [bit [31:0]];
  bit [31:0] exp_baddr [$];
  int        exp_blen [$];
  int        exp_bcmd [$];
  bit        exp_err [NUM_CMDS];
  bit [31:0] data_q [$];
  bit [31:0] wbuf [$];

  int cycle = 0;
  int mismatches = 0;
  int failures = 0;
  int cmds_sent = 0;
  int data_sent = 0;
  int cmd_cred = CMD_CREDITS;
  int data_cred = DATA_CREDITS;
  int cmd_returned = 0;
  int data_returned = 0;
  int done_cnt = 0;
  int aw_idx = 0;
  int w_idx = 0;
  int w_beat = 0;
  int b_idx = 0;
  int cmds_closed = 0;

  // slave side of the burst in flight
  bit        aw_have = 1'b0;
  bit        w_have = 1'b0;
  bit        b_pend = 1'b0;
  bit        b_err = 1'b0;
  int        b_wait = 0;
  int        aw_cmd = 0;
  bit [31:0] aw_base = '0;

  axi_write_dma u_axi_write_dma (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd_addr    (cmd_addr),
    .cmd_len     (cmd_len),
    .cmd_credit  (cmd_credit),
    .data_valid  (data_valid),
    .data_word   (data_word),
    .data_credit (data_credit),
    .awaddr      (awaddr),
    .awlen       (awlen),
    .awsize      (awsize),
    .awburst     (awburst),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wlast       (wlast),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .done        (done),
    .done_err    (done_err)
  );

  always #5 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    mismatches++;
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // random command plus its data words and expected bursts
  task automatic queue_command(output bit [31:0] base, output int beats);
    int        left;
    int        k;
    bit [31:0] addr;
    bit [31:0] word;
    beats = 1 + int'($urandom % MAX_BEATS);
    base = 32'h1000_0000 + (32'(cmds_sent) << 12) + (($urandom % 256) << 2);
    for (k = 0; k < beats; k++) begin
      word = $urandom;
      data_q.push_back(word);
      exp_mem[base + 32'(4 * k)] = word;
    end
    left = beats;
    addr = base;
    while (left > 0) begin
      exp_baddr.push_back(addr);
      exp_blen.push_back((left > MAX_BURST_LEN ? MAX_BURST_LEN : left) - 1);
      exp_bcmd.push_back(cmds_sent);
      addr = addr + 32'(MAX_BURST_LEN * NUM_DBYTES);
      left = left - MAX_BURST_LEN;
    end
  endtask

  task automatic check_final_state();
    assert (cmd_cred == CMD_CREDITS)
      else report_mismatch("cmd credits", 32'(cmd_cred), 32'(CMD_CREDITS));
    assert (data_cred == DATA_CREDITS)
      else report_mismatch("data credits", 32'(data_cred), 32'(DATA_CREDITS));
    assert (cmd_returned == cmds_sent)
      else report_mismatch("cmd_credit pulses", 32'(cmd_returned), 32'(cmds_sent));
    assert (data_returned == data_sent)
      else report_mismatch("data_credit pulses", 32'(data_returned), 32'(data_sent));
    assert (data_q.size() == 0) else report_failure("core still holds unsent data words");
    assert (aw_idx == exp_baddr.size())
      else report_mismatch("AW burst count", 32'(aw_idx), 32'(exp_baddr.size()));
    foreach (exp_mem[a]) begin
      assert (mem.exists(a)) else report_failure($sformatf("address %h never written", a));
      if (mem.exists(a)) begin
        assert (mem[a] == exp_mem[a])
          else report_mismatch($sformatf("mem[%h]", a), mem[a], exp_mem[a]);
      end
    end
  endtask

  // core: spends a credit per command and per data word
  always @(posedge clk) begin
    bit [31:0] base;
    int        beats;
    if (reset) begin
      cmd_valid  <= 1'b0;
      data_valid <= 1'b0;
    end else begin
      cmd_cred = cmd_cred + int'(cmd_credit);
      data_cred = data_cred + int'(data_credit);
      cmd_returned = cmd_returned + int'(cmd_credit);
      data_returned = data_returned + int'(data_credit);
      assert (cmd_cred <= CMD_CREDITS && data_cred <= DATA_CREDITS)
        else report_failure("credit returned that was never spent");
      cmd_valid  <= 1'b0;
      data_valid <= 1'b0;
      if (cmds_sent < NUM_CMDS && cmd_cred > 0 && $urandom % 2 == 0) begin
        queue_command(base, beats);
        cmd_valid <= 1'b1;
        cmd_addr  <= base;
        cmd_len   <= LEN_W'(beats - 1);
        cmd_cred--;
        cmds_sent++;
      end
      if (data_q.size() > 0 && data_cred > 0 && $urandom % 4 != 0) begin
        data_word  <= data_q.pop_front();
        data_valid <= 1'b1;
        data_cred--;
        data_sent++;
      end
    end
  end

  // memory slave with random stalls and occasional SLVERR
  always @(posedge clk) begin
    bit [31:0] exp_word;
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= $urandom % 4 != 0;
      wready  <= $urandom % 4 != 0;
      if (awvalid && awready) begin
        assert (aw_idx < exp_baddr.size()) else report_failure("AW with no burst expected");
        if (aw_idx < exp_baddr.size()) begin
          assert (awaddr == exp_baddr[aw_idx])
            else report_mismatch("awaddr", awaddr, exp_baddr[aw_idx]);
          assert (int'(awlen) == exp_blen[aw_idx])
            else report_mismatch("awlen", 32'(awlen), 32'(exp_blen[aw_idx]));
          aw_cmd = exp_bcmd[aw_idx];
        end
        assert (awsize == AXI_SIZE) else report_mismatch("awsize", 32'(awsize), 32'(AXI_SIZE));
        assert (awburst == BURST_INCR)
          else report_mismatch("awburst", 32'(awburst), 32'(BURST_INCR));
        aw_base = awaddr;
        aw_have = 1'b1;
        aw_idx++;
      end
      if (wvalid && wready) begin
        assert (w_idx < exp_blen.size()) else report_failure("W beat with no burst expected");
        if (w_idx < exp_blen.size()) begin
          exp_word = exp_mem[exp_baddr[w_idx] + 32'(4 * w_beat)];
          assert (wdata == exp_word) else report_mismatch("wdata", wdata, exp_word);
          assert (wlast == (w_beat == exp_blen[w_idx]))
            else report_mismatch("wlast", 32'(wlast), 32'(w_beat == exp_blen[w_idx]));
        end
        assert (wstrb == '1) else report_mismatch("wstrb", 32'(wstrb), 32'hf);
        wbuf.push_back(wdata);
        w_beat++;
        if (wlast) begin
          w_have = 1'b1;
          w_beat = 0;
          w_idx++;
        end
      end
      if (b_pend) begin
        if (bvalid && bready) begin
          bvalid <= 1'b0;
          b_pend = 1'b0;
          // response to a command's final burst closes that command
          if (b_idx + 1 >= exp_bcmd.size() || exp_bcmd[b_idx + 1] != exp_bcmd[b_idx]) begin
            cmds_closed++;
          end
          b_idx++;
        end else if (!bvalid) begin
          if (b_wait == 0) begin
            bvalid <= 1'b1;
            bresp  <= b_err ? RESP_SLVERR : RESP_OKAY;
          end else begin
            b_wait--;
          end
        end
      end
      // address and data both in, write memory and schedule B
      if (aw_have && w_have && !b_pend) begin
        foreach (wbuf[i]) begin
          mem[aw_base + 32'(4 * i)] = wbuf[i];
        end
        wbuf.delete();
        aw_have = 1'b0;
        w_have = 1'b0;
        b_pend = 1'b1;
        b_wait = int'($urandom % 4);
        b_err = $urandom % 20 == 0;
        if (b_err) begin
          exp_err[aw_cmd] = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && done) begin
      assert (done_cnt < NUM_CMDS) else report_failure("done pulse with no command left");
      if (done_cnt < NUM_CMDS) begin
        assert (done_cnt < cmds_closed)
          else report_failure("done pulse before the last response of its command");
        assert (done_err == exp_err[done_cnt])
          else report_mismatch("done_err", 32'(done_err), 32'(exp_err[done_cnt]));
      end
      done_cnt++;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (reset && cycle > 0) begin
      assert (!awvalid && !wvalid && !bready && !done && !cmd_credit && !data_credit)
        else report_failure("DUT outputs active during reset");
    end
  end

  initial begin
    void'($urandom(32'h8212));
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    while (done_cnt < NUM_CMDS && cycle < CYCLE_LIMIT) begin
      @(negedge clk);
    end
    if (done_cnt < NUM_CMDS) begin
      report_failure("cycle limit reached before all commands completed");
    end else begin
      // last credit pulses trail the final done
      repeat (4) @(negedge clk);
      check_final_state();
    end
    $display("errors: %0d mismatch, %0d other, %0d assertion", mismatches, failures,
             u_axi_write_dma.u_assertions.failures);
    if (mismatches + failures + u_axi_write_dma.u_assertions.failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim.f */
source/axi_write_pkg.sv
source/write_cmd_intake.sv
source/write_data_buffer.sv
source/axi_mm_write.sv
source/write_resp_collector.sv
source/axi_write_dma.sv
test/axi_write_dma_assertions.sv
test/axi_write_dma_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the axi_write_dma testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f \
  --top-module axi_write_dma_tb \
  -o axi_write_dma_sim

./obj_dir/axi_write_dma_sim | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
